// ==== all.f ====
+incdir+tests
common/c64_audio_pkg.sv
source/digimax_dac.sv
source/fm_compressor.sv
source/audio_mixer.sv
source/c64_audio_top.sv
tests/tb_c64_audio.sv

// ==== common/c64_audio_pkg.sv ====
// ================================================
// Types and constants shared by the audio path
// Sample widths are fixed for the whole design
// Compressor defaults may be overridden at the top level
// ================================================

package c64_audio_pkg;

	// ================================================
	// Widths
	// ================================================

	// FM sample and final output width
	localparam int SAMPLE_W = 16;

	// Raw SID sample width
	localparam int SID_W = 18;

	// One DigiMax channel plus another
	localparam int DAC_W = 9;

	// ================================================
	// Compressor defaults
	// ================================================

	// Slope divisor above the knee
	localparam int COMP_F_DEF = 4;

	// Gain below the knee
	localparam int COMP_A_DEF = 2;

	// ================================================
	// Enums
	// ================================================

	// IO window that carries the DigiMax registers
	typedef enum logic [1:0] {
		DIGIMAX_OFF = 2'd0,
		DIGIMAX_IOE = 2'd1,
		DIGIMAX_IOF = 2'd2
	} digimax_sel_e;

	// Channel layout guessed from the activity flags
	typedef enum logic [1:0] {
		DAC_MONO   = 2'd0,
		DAC_STEREO = 2'd1,
		DAC_QUAD   = 2'd2
	} dac_mode_e;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the audio path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module tb_c64_audio -Mdir obj_dir -o sim_c64_audio
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_c64_audio)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF "** PASS **" <<< "$output"; then
	exit 0
fi
exit 1

// ==== source/audio_mixer.sv ====
// ================================================
// Final mix of FM, SID, DigiMax and tape click
// Two clocks of latency and saturation to 16-bit signed
// ================================================

module audio_mixer (
	input  logic                                      clk_sys,
	input  logic                                      reset_n,
	input  logic signed [c64_audio_pkg::SAMPLE_W-1:0] fm_i,
	input  logic signed [c64_audio_pkg::SID_W-1:0]    sid_left_i,
	input  logic signed [c64_audio_pkg::SID_W-1:0]    sid_right_i,
	input  logic [c64_audio_pkg::DAC_W-1:0]           dac_l_i,
	input  logic [c64_audio_pkg::DAC_W-1:0]           dac_r_i,
	input  logic                                      cass_snd_i,
	output logic signed [c64_audio_pkg::SAMPLE_W-1:0] audio_l_o,
	output logic signed [c64_audio_pkg::SAMPLE_W-1:0] audio_r_o
);
	import c64_audio_pkg::*;

	localparam int SUM_W = SAMPLE_W + 1;

	logic [SUM_W-1:0] sum_l;
	logic [SUM_W-1:0] sum_r;

	// FM plus SID/4 plus DAC*64 plus 1024 for the tape click
	function automatic logic [SUM_W-1:0] mix_sum(
		input logic [SAMPLE_W-1:0] fm,
		input logic [SID_W-1:0]    sid,
		input logic [DAC_W-1:0]    dac,
		input logic                cass
	);
		mix_sum = {fm[SAMPLE_W-1], fm}
			+ {sid[SID_W-1], sid[SID_W-1:2]}
			+ {2'b00, dac, 6'd0}
			+ {6'd0, cass, 10'd0};
	endfunction

	// Top two bits differ on overflow
	function automatic logic [SAMPLE_W-1:0] saturate(input logic [SUM_W-1:0] sum);
		if (sum[SUM_W-1] != sum[SUM_W-2])
			saturate = {sum[SUM_W-1], {(SAMPLE_W-1){~sum[SUM_W-1]}}};
		else
			saturate = sum[SAMPLE_W-1:0];
	endfunction

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			sum_l     <= '0;
			sum_r     <= '0;
			audio_l_o <= '0;
			audio_r_o <= '0;
		end else begin
			sum_l     <= mix_sum(fm_i, sid_left_i, dac_l_i, cass_snd_i);
			sum_r     <= mix_sum(fm_i, sid_right_i, dac_r_i, cass_snd_i);
			audio_l_o <= saturate(sum_l);
			audio_r_o <= saturate(sum_r);
		end
	end

endmodule

// ==== source/c64_audio_top.sv ====
// ================================================
// Audio output path of the home computer core
// FM in to out is 4 clocks and SID or tape is 2
// A DigiMax write reaches the outputs after 5 clocks
// ================================================

module c64_audio_top #(
	parameter int COMP_F = c64_audio_pkg::COMP_F_DEF,
	parameter int COMP_A = c64_audio_pkg::COMP_A_DEF
) (
	input  logic                                      clk_sys,
	input  logic                                      reset_n,
	// CPU bus
	input  logic                                      ioe_i,
	input  logic                                      iof_i,
	input  logic                                      ram_we_n_i,
	input  logic [2:0]                                addr_i,
	input  logic [7:0]                                data_i,
	// Configuration
	input  c64_audio_pkg::digimax_sel_e               digimax_sel_i,
	// Sample sources
	input  logic signed [c64_audio_pkg::SAMPLE_W-1:0] fm_sample_i,
	input  logic signed [c64_audio_pkg::SID_W-1:0]    sid_left_i,
	input  logic signed [c64_audio_pkg::SID_W-1:0]    sid_right_i,
	input  logic                                      cass_snd_i,
	output logic signed [c64_audio_pkg::SAMPLE_W-1:0] audio_l_o,
	output logic signed [c64_audio_pkg::SAMPLE_W-1:0] audio_r_o
);
	import c64_audio_pkg::*;

	logic        [DAC_W-1:0]    dac_l;
	logic        [DAC_W-1:0]    dac_r;
	logic signed [SAMPLE_W-1:0] fm_comp;

	digimax_dac u_digimax_dac (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.ioe_i         (ioe_i),
		.iof_i         (iof_i),
		.ram_we_n_i    (ram_we_n_i),
		.addr_i        (addr_i),
		.data_i        (data_i),
		.digimax_sel_i (digimax_sel_i),
		.dac_l_o       (dac_l),
		.dac_r_o       (dac_r)
	);

	fm_compressor #(
		.COMP_F (COMP_F),
		.COMP_A (COMP_A)
	) u_fm_compressor (
		.clk_sys  (clk_sys),
		.reset_n  (reset_n),
		.sample_i (fm_sample_i),
		.sample_o (fm_comp)
	);

	audio_mixer u_audio_mixer (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.fm_i        (fm_comp),
		.sid_left_i  (sid_left_i),
		.sid_right_i (sid_right_i),
		.dac_l_i     (dac_l),
		.dac_r_i     (dac_r),
		.cass_snd_i  (cass_snd_i),
		.audio_l_o   (audio_l_o),
		.audio_r_o   (audio_r_o)
	);

endmodule

// ==== source/digimax_dac.sv ====
// ================================================
// DigiMax sample player on the DE00 or DF00 window
// addr_i and data_i must hold while the window is high
// Levels change 3 clocks after the window rises
// ================================================

module digimax_dac (
	input  logic                            clk_sys,
	input  logic                            reset_n,
	input  logic                            ioe_i,
	input  logic                            iof_i,
	input  logic                            ram_we_n_i,
	input  logic [2:0]                      addr_i,
	input  logic [7:0]                      data_i,
	input  c64_audio_pkg::digimax_sel_e     digimax_sel_i,
	output logic [c64_audio_pkg::DAC_W-1:0] dac_l_o,
	output logic [c64_audio_pkg::DAC_W-1:0] dac_r_o
);
	import c64_audio_pkg::*;

	logic       ioe_q;
	logic       iof_q;
	logic       ioe_we;
	logic       iof_we;
	logic       win_we;
	logic [7:0] chan [4];
	logic [3:0] act;
	dac_mode_e  mode;

	function automatic logic [DAC_W-1:0] chan_sum(input logic [7:0] a, input logic [7:0] b);
		chan_sum = {1'b0, a} + {1'b0, b};
	endfunction

	// Rising edge of each window while the CPU writes
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			ioe_q  <= 1'b0;
			iof_q  <= 1'b0;
			ioe_we <= 1'b0;
			iof_we <= 1'b0;
		end else begin
			ioe_q  <= ioe_i;
			iof_q  <= iof_i;
			ioe_we <= ~ioe_q & ioe_i & ~ram_we_n_i;
			iof_we <= ~iof_q & iof_i & ~ram_we_n_i;
		end
	end

	always_comb begin
		case (digimax_sel_i)
			DIGIMAX_IOE: win_we = ioe_we;
			DIGIMAX_IOF: win_we = iof_we;
			default:     win_we = 1'b0;
		endcase
	end

	// Channel registers are cleared when the player is switched off
	always_ff @(posedge clk_sys) begin
		if (!reset_n || digimax_sel_i == DIGIMAX_OFF) begin
			chan <= '{default: '0};
			act  <= '0;
		end else if (win_we && !addr_i[2]) begin
			chan[addr_i[1:0]] <= data_i;
			if (data_i != 8'd0)
				act[addr_i[1:0]] <= 1'b1;
		end
	end

	// Guess the layout from which channels have seen data
	always_comb begin
		if (act < 4'd2)
			mode = DAC_MONO;
		else if (act == 4'd2)
			mode = DAC_STEREO;
		else
			mode = DAC_QUAD;
	end

	always_ff @(posedge clk_sys) begin
		case (mode)
			DAC_MONO: begin
				dac_l_o <= chan_sum(chan[0], chan[0]);
				dac_r_o <= chan_sum(chan[0], chan[0]);
			end
			DAC_STEREO: begin
				dac_l_o <= chan_sum(chan[1], chan[1]);
				dac_r_o <= chan_sum(chan[0], chan[0]);
			end
			default: begin
				dac_l_o <= chan_sum(chan[1], chan[2]);
				dac_r_o <= chan_sum(chan[0], chan[3]);
			end
		endcase
	end

	// IOE and IOF never open together on the CPU bus
	a_one_strobe: assert property (@(posedge clk_sys) disable iff (!reset_n)
		!(ioe_we && iof_we));

endmodule

// ==== source/fm_compressor.sv ====
// ================================================
// FM sample attenuation to 7/8 and two-slope compression
// Two clocks of latency with one sample accepted per clock
// ================================================

module fm_compressor #(
	parameter int COMP_F = c64_audio_pkg::COMP_F_DEF,
	parameter int COMP_A = c64_audio_pkg::COMP_A_DEF
) (
	input  logic                                   clk_sys,
	input  logic                                   reset_n,
	input  logic signed [c64_audio_pkg::SAMPLE_W-1:0] sample_i,
	output logic signed [c64_audio_pkg::SAMPLE_W-1:0] sample_o
);
	import c64_audio_pkg::*;

	// Knee is rounded up so the upper slope cannot overflow
	localparam int KNEE_I   = ((32767 * (COMP_F - 1)) / ((COMP_F * COMP_A) - 1)) + 1;
	localparam int OFFSET_I = KNEE_I * COMP_A;

	localparam logic [SAMPLE_W-1:0] KNEE   = KNEE_I[SAMPLE_W-1:0];
	localparam logic [SAMPLE_W-1:0] OFFSET = OFFSET_I[SAMPLE_W-1:0];
	localparam logic [SAMPLE_W-1:0] GAIN_A = COMP_A[SAMPLE_W-1:0];
	localparam logic [SAMPLE_W-1:0] DIV_F  = COMP_F[SAMPLE_W-1:0];

	logic signed [SAMPLE_W-1:0] stage1_q;
	logic        [SAMPLE_W-1:0] mag;
	logic        [SAMPLE_W-1:0] comp;

	always_comb begin
		mag = stage1_q[SAMPLE_W-1] ? (~stage1_q + 1'b1) : stage1_q;
		if (mag < KNEE)
			comp = mag * GAIN_A;
		else
			comp = ((mag - KNEE) / DIV_F) + OFFSET;
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			stage1_q <= '0;
			sample_o <= '0;
		end else begin
			stage1_q <= sample_i - (sample_i >>> 3);
			// Put the sign back on the compressed magnitude
			sample_o <= stage1_q[SAMPLE_W-1] ? (~comp + 1'b1) : comp;
		end
	end

	// Compression keeps the sign of the attenuated sample
	a_keep_sign: assert property (@(posedge clk_sys) disable iff (!reset_n)
		stage1_q != '0 |=> sample_o[SAMPLE_W-1] == $past(stage1_q[SAMPLE_W-1]));

endmodule

// ==== tests/tb_c64_audio_vectors.svh ====
// ================================================
// Stimulus table for the audio path testbench
// Rows run in order and DigiMax rows build on earlier writes
// DAC columns hold the per-side level of the guessed layout
// ================================================

task automatic load_vectors();
	int k;
	int rv;
	int fm_v;

	// ================================================
	// FM path, compressor below and above the knee
	// ================================================
	// Each row holds name, select, fm, sid left, sid right, tape, latency, dac left, dac right
	sample_entry("fm_small_pos", DIGIMAX_OFF, 1000, 0, 0, 0, 4, 0, 0);
	sample_entry("fm_small_neg", DIGIMAX_OFF, -1000, 0, 0, 0, 4, 0, 0);
	sample_entry("fm_below_knee", DIGIMAX_OFF, 16049, 0, 0, 0, 4, 0, 0);
	sample_entry("fm_at_knee", DIGIMAX_OFF, 16050, 0, 0, 0, 4, 0, 0);
	sample_entry("fm_big_pos", DIGIMAX_OFF, 30000, 0, 0, 0, 4, 0, 0);
	sample_entry("fm_big_neg", DIGIMAX_OFF, -30000, 0, 0, 0, 4, 0, 0);
	for (k = 0; k < 4; k++) begin
		rv = $random(seed);
		fm_v = $signed(rv[15:0]);
		sample_entry($sformatf("fm_random_%0d", k), DIGIMAX_OFF, fm_v, 0, 0, 0, 4, 0, 0);
	end
	sample_entry("fm_zero", DIGIMAX_OFF, 0, 0, 0, 0, 4, 0, 0);

	// ================================================
	// SID, tape click and saturation
	// ================================================
	sample_entry("sid_split", DIGIMAX_OFF, 0, 4000, -8000, 0, 2, 0, 0);
	sample_entry("sid_odd", DIGIMAX_OFF, 0, -7, 7, 0, 2, 0, 0);
	sample_entry("tape_click", DIGIMAX_OFF, 0, 0, 0, 1, 2, 0, 0);
	sample_entry("sid_tape_edge", DIGIMAX_OFF, 0, 131071, -131072, 1, 2, 0, 0);
	sample_entry("clamp_pos", DIGIMAX_OFF, 32767, 131071, 131071, 0, 4, 0, 0);
	sample_entry("clamp_neg", DIGIMAX_OFF, -32768, -131072, -131072, 0, 4, 0, 0);

	// ================================================
	// DigiMax layout and window selection
	// ================================================
	sample_entry("dac_idle", DIGIMAX_IOE, 0, 0, 0, 0, 4, 0, 0);
	// Each write row holds name, window, address, data, dac left, dac right
	write_entry("mono_ch0", WIN_IOE, 0, 16, 2 * 16, 2 * 16);
	sample_entry("off_clears_mono", DIGIMAX_OFF, 0, 0, 0, 0, 4, 0, 0);
	sample_entry("ioe_again", DIGIMAX_IOE, 0, 0, 0, 0, 4, 0, 0);
	write_entry("stereo_ch1", WIN_IOE, 1, 32, 2 * 32, 0);
	write_entry("quad_ch2", WIN_IOE, 2, 8, 32 + 8, 0);
	write_entry("quad_ch3", WIN_IOE, 3, 4, 32 + 8, 0 + 4);
	write_entry("quad_ch0", WIN_IOE, 0, 3, 32 + 8, 3 + 4);
	write_entry("iof_ignored", WIN_IOF, 0, 127, 40, 7);
	// Address 4 would land on channel 0 if bit 2 were not checked
	write_entry("addr_bit2_ignored", WIN_IOE, 4, 85, 40, 7);
	sample_entry("select_iof", DIGIMAX_IOF, 0, 0, 0, 0, 4, 40, 7);
	write_entry("ioe_ignored", WIN_IOE, 1, 127, 40, 7);
	write_entry("iof_ch1", WIN_IOF, 1, 16, 16 + 8, 7);
	sample_entry("dac_with_tape", DIGIMAX_IOF, 0, 0, 0, 1, 2, 24, 7);
	sample_entry("off_clears_quad", DIGIMAX_OFF, 0, 0, 0, 0, 4, 0, 0);
endtask

// ==== tests/tb_c64_audio.sv ====
// ================================================
// Testbench for the audio output path
// Runs the rows of the included table in order
// Expected values follow the mixing and compression rules
// ================================================

module tb_c64_audio;
	import c64_audio_pkg::*;

	localparam int ACT_SAMPLE = 0;
	localparam int ACT_WRITE  = 1;
	localparam int WIN_IOE    = 0;
	localparam int WIN_IOF    = 1;
	localparam int TIMEOUT    = 32;
	localparam int WRITE_LAT  = 5;

	// Knee and upper offset for the default slope and gain
	localparam int KNEE   = (32767 * (COMP_F_DEF - 1)) / (COMP_F_DEF * COMP_A_DEF - 1) + 1;
	localparam int OFFSET = KNEE * COMP_A_DEF;

	logic                       clk_sys = 1'b0;
	logic                       reset_n;
	logic                       ioe;
	logic                       iof;
	logic                       ram_we_n;
	logic [2:0]                 addr;
	logic [7:0]                 data;
	digimax_sel_e               digimax_sel;
	logic signed [SAMPLE_W-1:0] fm_sample;
	logic signed [SID_W-1:0]    sid_left;
	logic signed [SID_W-1:0]    sid_right;
	logic                       cass_snd;
	logic signed [SAMPLE_W-1:0] audio_l;
	logic signed [SAMPLE_W-1:0] audio_r;

	integer seed;
	int     tests;
	int     errors;

	// ================================================
	// Test table storage
	// ================================================
	string        row_name[$];
	int           row_act[$];
	digimax_sel_e row_sel[$];
	int           row_win[$];
	int           row_addr[$];
	int           row_data[$];
	int           row_fm[$];
	int           row_sid_l[$];
	int           row_sid_r[$];
	int           row_cass[$];
	int           row_lat[$];
	int           row_exp_l[$];
	int           row_exp_r[$];

	// Sample inputs held by the last sample row
	int last_fm;
	int last_sid_l;
	int last_sid_r;
	int last_cass;

	always #2 clk_sys = ~clk_sys;

	c64_audio_top u_c64_audio_top (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.ioe_i         (ioe),
		.iof_i         (iof),
		.ram_we_n_i    (ram_we_n),
		.addr_i        (addr),
		.data_i        (data),
		.digimax_sel_i (digimax_sel),
		.fm_sample_i   (fm_sample),
		.sid_left_i    (sid_left),
		.sid_right_i   (sid_right),
		.cass_snd_i    (cass_snd),
		.audio_l_o     (audio_l),
		.audio_r_o     (audio_r)
	);

	// ================================================
	// Reference model
	// ================================================

	// Division rounding toward minus infinity, as an arithmetic shift does
	function automatic int floor_div(input int a, input int d);
		if (a >= 0)
			return a / d;
		return -((-a + d - 1) / d);
	endfunction

	// 7/8 attenuation then two-slope compression of the magnitude
	function automatic int fm_expect(input int s);
		int v;
		int mag;
		int res;
		v = s - floor_div(s, 8);
		mag = (v < 0) ? -v : v;
		if (mag < KNEE)
			res = mag * COMP_A_DEF;
		else
			res = (mag - KNEE) / COMP_F_DEF + OFFSET;
		return (v < 0) ? -res : res;
	endfunction

	function automatic int mix_side(input int fm, input int sid, input int dac, input int cass);
		int sum;
		sum = fm + floor_div(sid, 4) + dac * 64 + ((cass != 0) ? 1024 : 0);
		if (sum > 32767)
			return 32767;
		if (sum < -32768)
			return -32768;
		return sum;
	endfunction

	// dac_l and dac_r are the per-side DAC levels the layout rule gives
	task automatic sample_entry(input string name, input digimax_sel_e sel, input int fm,
		input int sid_l, input int sid_r, input int cass, input int lat,
		input int dac_l, input int dac_r);
		row_name.push_back(name);
		row_act.push_back(ACT_SAMPLE);
		row_sel.push_back(sel);
		row_win.push_back(WIN_IOE);
		row_addr.push_back(0);
		row_data.push_back(0);
		row_fm.push_back(fm);
		row_sid_l.push_back(sid_l);
		row_sid_r.push_back(sid_r);
		row_cass.push_back(cass);
		row_lat.push_back(lat);
		row_exp_l.push_back(mix_side(fm_expect(fm), sid_l, dac_l, cass));
		row_exp_r.push_back(mix_side(fm_expect(fm), sid_r, dac_r, cass));
		last_fm = fm;
		last_sid_l = sid_l;
		last_sid_r = sid_r;
		last_cass = cass;
	endtask

	task automatic write_entry(input string name, input int win, input int addr_v,
		input int data_v, input int dac_l, input int dac_r);
		row_name.push_back(name);
		row_act.push_back(ACT_WRITE);
		row_sel.push_back(DIGIMAX_OFF);
		row_win.push_back(win);
		row_addr.push_back(addr_v);
		row_data.push_back(data_v);
		row_fm.push_back(last_fm);
		row_sid_l.push_back(last_sid_l);
		row_sid_r.push_back(last_sid_r);
		row_cass.push_back(last_cass);
		row_lat.push_back(WRITE_LAT);
		row_exp_l.push_back(mix_side(fm_expect(last_fm), last_sid_l, dac_l, last_cass));
		row_exp_r.push_back(mix_side(fm_expect(last_fm), last_sid_r, dac_r, last_cass));
	endtask

	`include "tb_c64_audio_vectors.svh"

	// ================================================
	// Driving and checking
	// ================================================

	task automatic wait_edges(input int n, output bit timed_out);
		int count;
		count = 0;
		while (count < n && count < TIMEOUT) begin
			@(posedge clk_sys);
			count++;
		end
		timed_out = (count < n);
	endtask

	task automatic run_row(input int i);
		int                         lat;
		int                         v;
		int                         el;
		int                         er;
		bit                         timed_out;
		logic signed [SAMPLE_W-1:0] exp_l;
		logic signed [SAMPLE_W-1:0] exp_r;
		@(posedge clk_sys);
		if (row_act[i] == ACT_WRITE) begin
			v = row_addr[i];
			addr <= v[2:0];
			v = row_data[i];
			data <= v[7:0];
			ram_we_n <= 1'b0;
			if (row_win[i] == WIN_IOE)
				ioe <= 1'b1;
			else
				iof <= 1'b1;
		end else begin
			digimax_sel <= row_sel[i];
			v = row_fm[i];
			fm_sample <= v[SAMPLE_W-1:0];
			v = row_sid_l[i];
			sid_left <= v[SID_W-1:0];
			v = row_sid_r[i];
			sid_right <= v[SID_W-1:0];
			cass_snd <= (row_cass[i] != 0);
		end
		lat = row_lat[i];
		wait_edges(lat, timed_out);
		@(negedge clk_sys);
		el = row_exp_l[i];
		er = row_exp_r[i];
		exp_l = el[SAMPLE_W-1:0];
		exp_r = er[SAMPLE_W-1:0];
		tests++;
		if (timed_out) begin
			$display("%s: gave up waiting for %0d cycles after %0d cycles",
				row_name[i], lat, TIMEOUT);
			errors++;
		end else if (audio_l !== exp_l || audio_r !== exp_r) begin
			$display("FAILED %s expected l=%0d r=%0d actual l=%0d r=%0d",
				row_name[i], exp_l, exp_r, audio_l, audio_r);
			errors++;
		end else begin
			$display("ok     %s l=%0d r=%0d", row_name[i], audio_l, audio_r);
		end
		// Close the window so the next write sees a rising edge
		if (row_act[i] == ACT_WRITE) begin
			@(posedge clk_sys);
			ioe <= 1'b0;
			iof <= 1'b0;
			ram_we_n <= 1'b1;
		end
	endtask

	initial begin
		bit timed_out;
		int i;
		seed = 32'he9b4_3e71;
		reset_n = 1'b0;
		ioe = 1'b0;
		iof = 1'b0;
		ram_we_n = 1'b1;
		addr = 3'd0;
		data = 8'd0;
		digimax_sel = DIGIMAX_OFF;
		fm_sample = '0;
		sid_left = '0;
		sid_right = '0;
		cass_snd = 1'b0;
		tests = 0;
		errors = 0;
		last_fm = 0;
		last_sid_l = 0;
		last_sid_r = 0;
		last_cass = 0;
		load_vectors();

		wait_edges(3, timed_out);
		reset_n <= 1'b1;
		// Outputs become valid 4 cycles after reset
		wait_edges(4, timed_out);

		for (i = 0; i < row_name.size(); i++)
			run_row(i);

		$display("tests %0d, passed %0d, failed %0d", tests, tests - errors, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
